/* Bender.yml */
package:
  name: astar_grid

sources:
  - verilog/astar_pkg.sv
  - verilog/neighbor_gen.sv
  - verilog/open_list.sv
  - verilog/search_ctrl.sv
  - verilog/astar_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/astar_tb.sv

/* dv/astar_ref.svh */
`ifndef ASTAR_REF_SVH
`define ASTAR_REF_SVH

// dijkstra over the same 8-way grid returning {found, cost}
function automatic logic [COST_W:0] ref_path_cost(
  input logic [NUM_NODES-1:0] map,
  input int                   src,
  input int                   dst
);
  int reach [NUM_NODES];  // -1 means unreached
  bit fixed [NUM_NODES];
  int u;
  int best;
  int vx;
  int vy;
  int v;
  int step;
  for (int i = 0; i < NUM_NODES; i++)
  begin
    reach[i] = -1;
    fixed[i] = 1'b0;
  end
  if (map[src] || map[dst])
    return '0;
  reach[src] = 0;
  for (int k = 0; k < NUM_NODES; k++)
  begin
    u    = -1;
    best = 0;
    for (int i = 0; i < NUM_NODES; i++)
    begin
      if (!fixed[i] && reach[i] >= 0 && (u < 0 || reach[i] < best))
      begin
        u    = i;
        best = reach[i];
      end
    end
    if (u < 0)
      break;  // nothing reachable left
    if (u == dst)
      return {1'b1, COST_W'(best)};
    fixed[u] = 1'b1;
    for (int dy = -1; dy <= 1; dy++)
    begin
      for (int dx = -1; dx <= 1; dx++)
      begin
        vx = u % GRID_DIM + dx;
        vy = u / GRID_DIM + dy;
        if ((dx == 0 && dy == 0) || vx < 0 || vy < 0 || vx >= GRID_DIM || vy >= GRID_DIM)
          continue;
        v    = vy * GRID_DIM + vx;
        step = (dx != 0 && dy != 0) ? STEP_DIAG : STEP_STRAIGHT;
        if (!map[v] && (reach[v] < 0 || best + step < reach[v]))
          reach[v] = best + step;
      end
    end
  end
  return '0;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

`endif

/* dv/astar_tb.sv */
`timescale 1ns/1ns

module astar_tb
  import astar_pkg::*;
();

  localparam logic [31:0] SEED           = 32'h12e3fe67;
  localparam int          RANDOM_RUNS    = 50;
  localparam int          TIMEOUT_CYCLES = 20000;

  logic                 sync;
  logic                 reset;
  logic                 start;
  node_t                start_node;
  node_t                goal_node;
  logic [NUM_NODES-1:0] obstacle_map;
  logic                 busy;
  logic                 done;
  logic                 found;
  logic [COST_W-1:0]    cost;

  logic [31:0]          rng_state;
  int                   issued;
  int                   checked;
  int                   done_count;
  logic                 exp_found_q [$];  // one entry per started search
  logic [COST_W-1:0]    exp_cost_q [$];

  `include "astar_ref.svh"

  astar_top i_dut (
    .sync           (sync),
    .reset          (reset),
    .start_i        (start),
    .start_node_i   (start_node),
    .goal_node_i    (goal_node),
    .obstacle_map_i (obstacle_map),
    .busy_o         (busy),
    .done_o         (done),
    .found_o        (found),
    .cost_o         (cost)
  );

  always #20 sync = ~sync;

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r         = rng_state;
  endtask

  // roughly one cell in four blocked
  task automatic random_map(output logic [NUM_NODES-1:0] map);
    logic [31:0] r;
    for (int i = 0; i < NUM_NODES; i++)
    begin
      next_rand(r);
      map[i] = r[7:0] < 8'd64;
    end
  endtask

  // entered and left 2 ns after a rising edge
  task automatic run_search(input logic [NUM_NODES-1:0] map, input int src, input int dst,
                            input bit poke_busy);
    logic [COST_W:0] exp_res;
    int              waited;
    obstacle_map   = map;
    start_node.idx = NODE_W'(src);
    goal_node.idx  = NODE_W'(dst);
    exp_res        = ref_path_cost(map, src, dst);
    exp_found_q.push_back(exp_res[COST_W]);
    exp_cost_q.push_back(exp_res[COST_W-1:0]);
    issued++;
    start = 1'b1;
    @(posedge sync);
    #2 start = 1'b0;
    if (poke_busy)
    begin
      repeat (4) @(posedge sync);
      #2;
      assert (busy == 1'b1)
      else report_fail($sformatf("CHECK FAILED busy_o: got %h, expected %h", busy, 1'b1));
      start = 1'b1;                 // must be ignored
      @(posedge sync);
      #2 start = 1'b0;
    end
    waited = 0;
    while (checked < issued)
    begin
      waited++;
      if (waited > TIMEOUT_CYCLES)
        report_fail("timeout waiting for the comparison of a search result");
      @(posedge sync);
    end
    repeat (3) @(posedge sync);     // window for a stray second done pulse
    #2;
    assert (done_count == issued)
    else report_fail($sformatf("CHECK FAILED done_o pulse count: got %h, expected %h",
                               done_count, issued));
    assert (busy == 1'b0)
    else report_fail($sformatf("CHECK FAILED busy_o: got %h, expected %h", busy, 1'b0));
  endtask

  always @(negedge sync)
  begin
    if (done)
      done_count = done_count + 1;
  end

  initial
  begin : compare
    logic              exp_found;
    logic [COST_W-1:0] exp_cost;
    int                waited;
    forever
    begin
      waited = 0;
      @(negedge sync);
      while (done !== 1'b1)
      begin
        waited++;
        if (waited > TIMEOUT_CYCLES)
          report_fail("timeout waiting for done_o");
        @(negedge sync);
      end
      assert (exp_found_q.size() > 0)
      else report_fail("done_o pulsed while no search was started");
      exp_found = exp_found_q.pop_front();
      exp_cost  = exp_cost_q.pop_front();
      assert (found == exp_found)
      else report_fail($sformatf("CHECK FAILED found_o: got %h, expected %h", found, exp_found));
      assert (cost == exp_cost)
      else report_fail($sformatf("CHECK FAILED cost_o: got %h, expected %h", cost, exp_cost));
      checked++;
    end
  end

  initial
  begin : stimulus
    logic [NUM_NODES-1:0] map;
    logic [31:0]          r;
    int                   src;
    int                   dst;
    sync         = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    start_node   = '0;
    goal_node    = '0;
    obstacle_map = '0;
    rng_state    = SEED;
    issued       = 0;
    checked      = 0;
    done_count   = 0;
    repeat (16) @(posedge sync);
    #2 reset = 1'b0;

    // corner to corner is seven diagonal steps
    assert (ref_path_cost('0, 0, NUM_NODES - 1) == {1'b1, COST_W'(98)})
    else report_fail("reference cost from corner to corner on an empty map is not 98");
    run_search('0, 0, 63, 1'b0);
    run_search('0, 7, 56, 1'b0);
    run_search('0, 9, 30, 1'b0);
    run_search('0, 35, 4, 1'b0);
    run_search('0, 29, 29, 1'b0);   // start equals goal

    map     = '0;
    map[12] = 1'b1;
    run_search(map, 12, 50, 1'b0);  // blocked start
    run_search(map, 50, 12, 1'b0);  // blocked goal

    // goal at (4,4) ringed by obstacles
    map = '0;
    for (int dy = -1; dy <= 1; dy++)
    begin
      for (int dx = -1; dx <= 1; dx++)
      begin
        if (dx != 0 || dy != 0)
          map[(4 + dy) * GRID_DIM + 4 + dx] = 1'b1;
      end
    end
    run_search(map, 0, 36, 1'b0);

    map     = '0;
    map[54] = 1'b1;
    map[55] = 1'b1;
    map[62] = 1'b1;
    run_search(map, 0, 63, 1'b0);   // corner goal cut off

    run_search('0, 0, 63, 1'b1);    // extra start while busy

    for (int n = 0; n < RANDOM_RUNS; n++)
    begin
      random_map(map);
      next_rand(r);
      src      = int'(r[5:0]);
      dst      = int'(r[11:6]);
      map[src] = 1'b0;
      map[dst] = 1'b0;
      run_search(map, src, dst, 1'b0);
    end

    if (checked == issued)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
      report_fail("not every search result was compared");
  end

endmodule

/* sources.f */
+incdir+dv
verilog/astar_pkg.sv
verilog/neighbor_gen.sv
verilog/open_list.sv
verilog/search_ctrl.sv
verilog/astar_top.sv
dv/astar_tb.sv

/* verilog/astar_pkg.sv */
package astar_pkg;

  // grid geometry
  localparam int GRID_DIM  = 8;
  localparam int NUM_NODES = GRID_DIM * GRID_DIM;  // also the open list depth
  localparam int COORD_W   = $clog2(GRID_DIM);
  localparam int NODE_W    = 2 * COORD_W;

  // path costs
  localparam int COST_W        = 11;  // f stays below 2048 on this grid
  localparam int STEP_STRAIGHT = 10;
  localparam int STEP_DIAG     = 14;

  localparam logic [COST_W-1:0] G_INF = '1;  // g of an unreached node

  // search_ctrl states
  localparam int ST_W = 3;
  localparam logic [ST_W-1:0] ST_IDLE  = 3'd0;
  localparam logic [ST_W-1:0] ST_CHECK = 3'd1;  // obstacle test, list clear
  localparam logic [ST_W-1:0] ST_SEED  = 3'd2;
  localparam logic [ST_W-1:0] ST_POP   = 3'd3;
  localparam logic [ST_W-1:0] ST_EVAL  = 3'd4;
  localparam logic [ST_W-1:0] ST_CAND  = 3'd5;
  localparam logic [ST_W-1:0] ST_WRITE = 3'd6;  // g write and insert

  // flat index or y/x pair with idx = y * GRID_DIM + x
  typedef union packed {
    logic [NODE_W-1:0] idx;
    struct packed {
      logic [COORD_W-1:0] y;
      logic [COORD_W-1:0] x;
    } xy;
  } node_t;

endpackage

/* verilog/astar_top.sv */
`timescale 1ns/1ns

module astar_top
  import astar_pkg::*;
(
  input  logic                 sync,
  input  logic                 reset,
  input  logic                 start_i,
  input  node_t                start_node_i,
  input  node_t                goal_node_i,
  input  logic [NUM_NODES-1:0] obstacle_map_i,  // bit idx set means blocked
  output logic                 busy_o,
  output logic                 done_o,
  output logic                 found_o,
  output logic [COST_W-1:0]    cost_o
);

  // pop and insert channels
  logic              pop_valid;
  logic              pop_ready;
  node_t             pop_node;
  logic [COST_W-1:0] pop_g;
  logic              empty;
  logic              ins_valid;
  node_t             ins_node;
  logic [COST_W-1:0] ins_g;
  logic [COST_W-1:0] ins_f;
  logic              clear;

  // neighbor candidates
  logic              load;
  node_t             load_node;
  logic              cand_valid;
  logic              cand_ready;
  node_t             cand_node;
  logic              cand_diag;
  logic              cand_last;

  neighbor_gen i_neighbor_gen (
    .sync         (sync),
    .reset        (reset),
    .load_i       (load),
    .node_i       (load_node),
    .cand_valid_o (cand_valid),
    .cand_ready_i (cand_ready),
    .cand_node_o  (cand_node),
    .cand_diag_o  (cand_diag),
    .cand_last_o  (cand_last)
  );

  open_list i_open_list (
    .sync        (sync),
    .reset       (reset),
    .clear_i     (clear),
    .ins_valid_i (ins_valid),
    .ins_node_i  (ins_node),
    .ins_g_i     (ins_g),
    .ins_f_i     (ins_f),
    .pop_valid_o (pop_valid),
    .pop_ready_i (pop_ready),
    .pop_node_o  (pop_node),
    .pop_g_o     (pop_g),
    .empty_o     (empty)
  );

  search_ctrl i_search_ctrl (
    .sync           (sync),
    .reset          (reset),
    .start_i        (start_i),
    .start_node_i   (start_node_i),
    .goal_node_i    (goal_node_i),
    .obstacle_map_i (obstacle_map_i),
    .pop_valid_i    (pop_valid),
    .pop_ready_o    (pop_ready),
    .pop_node_i     (pop_node),
    .pop_g_i        (pop_g),
    .empty_i        (empty),
    .ins_valid_o    (ins_valid),
    .ins_node_o     (ins_node),
    .ins_g_o        (ins_g),
    .ins_f_o        (ins_f),
    .clear_o        (clear),
    .load_o         (load),
    .load_node_o    (load_node),
    .cand_valid_i   (cand_valid),
    .cand_ready_o   (cand_ready),
    .cand_node_i    (cand_node),
    .cand_diag_i    (cand_diag),
    .cand_last_i    (cand_last),
    .busy_o         (busy_o),
    .done_o         (done_o),
    .found_o        (found_o),
    .cost_o         (cost_o)
  );

endmodule

/* verilog/neighbor_gen.sv */
`timescale 1ns/1ns

module neighbor_gen
  import astar_pkg::*;
(
  input  logic  sync,
  input  logic  reset,
  input  logic  load_i,
  input  node_t node_i,
  output logic  cand_valid_o,
  input  logic  cand_ready_i,
  output node_t cand_node_o,
  output logic  cand_diag_o,
  output logic  cand_last_o
);

  node_t      node_q;
  logic [2:0] dir_q;       // 0 NW, 1 N, 2 NE, 3 E, 4 SE, 5 S, 6 SW, 7 W
  logic [7:0] cur_mask;
  logic [7:0] upper_mask;
  logic       xfer;

  // one bit per direction whose step stays inside the grid
  function automatic logic [7:0] dir_mask(node_t n);
    logic w;
    logic e;
    logic up;
    logic dn;
    w  = n.xy.x != '0;
    e  = n.xy.x != COORD_W'(GRID_DIM - 1);
    up = n.xy.y != '0;
    dn = n.xy.y != COORD_W'(GRID_DIM - 1);
    return {w, dn & w, dn, dn & e, e, up & e, up, up & w};
  endfunction

  function automatic logic [2:0] lowest_dir(logic [7:0] m);
    logic [2:0] d;
    d = 3'd0;
    for (int i = 7; i >= 0; i--)
    begin
      if (m[i])
        d = 3'(i);
    end
    return d;
  endfunction

  assign cur_mask   = dir_mask(node_q);
  assign upper_mask = cur_mask & (8'hfe << dir_q);  // directions still to come
  assign xfer       = cand_valid_o & cand_ready_i;

  assign cand_diag_o = ~dir_q[0];            // even codes are diagonal
  assign cand_last_o = upper_mask == '0;

  always_comb
  begin
    cand_node_o = node_q;
    if (dir_q inside {3'd0, 3'd6, 3'd7})
      cand_node_o.xy.x = node_q.xy.x - 1'b1;
    if (dir_q inside {3'd2, 3'd3, 3'd4})
      cand_node_o.xy.x = node_q.xy.x + 1'b1;
    if (dir_q inside {3'd0, 3'd1, 3'd2})
      cand_node_o.xy.y = node_q.xy.y - 1'b1;  // north is lower y
    if (dir_q inside {3'd4, 3'd5, 3'd6})
      cand_node_o.xy.y = node_q.xy.y + 1'b1;
  end

  always_ff @(posedge sync or posedge reset)
  begin
    if (reset)
    begin
      cand_valid_o <= 1'b0;
      dir_q        <= 3'd0;
    end
    else if (load_i)
    begin
      cand_valid_o <= 1'b1;                  // every cell has 3+ neighbors
      dir_q        <= lowest_dir(dir_mask(node_i));
    end
    else if (xfer)
    begin
      if (cand_last_o)
        cand_valid_o <= 1'b0;
      else
        dir_q <= lowest_dir(upper_mask);     // skip off-grid steps
    end
  end

  always_ff @(posedge sync)
  begin
    if (load_i)
      node_q <= node_i;
  end

  a_cand_after_load: assert property (
    @(posedge sync) disable iff (reset) $rose(cand_valid_o) |-> $past(load_i));

endmodule

/* verilog/open_list.sv */
`timescale 1ns/1ns

module open_list
  import astar_pkg::*;
(
  input  logic              sync,
  input  logic              reset,
  input  logic              clear_i,
  input  logic              ins_valid_i,
  input  node_t             ins_node_i,
  input  logic [COST_W-1:0] ins_g_i,
  input  logic [COST_W-1:0] ins_f_i,
  output logic              pop_valid_o,
  input  logic              pop_ready_i,
  output node_t             pop_node_o,
  output logic [COST_W-1:0] pop_g_o,
  output logic              empty_o
);

  logic [NUM_NODES-1:0] ent_valid_q;
  node_t                ent_node_q [NUM_NODES];
  logic [COST_W-1:0]    ent_g_q    [NUM_NODES];
  logic [COST_W-1:0]    ent_f_q    [NUM_NODES];

  // running min-f scan
  logic [NODE_W-1:0] scan_idx_q;
  logic              scan_done_q;
  logic              best_found_q;
  logic [NODE_W-1:0] best_slot_q;
  logic [COST_W-1:0] best_f_q;

  logic              hit;
  logic [NODE_W-1:0] hit_slot;
  logic              free_found;
  logic [NODE_W-1:0] free_slot;
  logic [NODE_W-1:0] ins_slot;
  logic              ins_write;
  logic              pop_xfer;
  logic              scan_take;

  // lowest matching slot and lowest free slot
  always_comb
  begin
    hit        = 1'b0;
    hit_slot   = '0;
    free_found = 1'b0;
    free_slot  = '0;
    for (int i = NUM_NODES - 1; i >= 0; i--)
    begin
      if (ent_valid_q[i] && ent_node_q[i] == ins_node_i)
      begin
        hit      = 1'b1;
        hit_slot = NODE_W'(i);
      end
      if (!ent_valid_q[i])
      begin
        free_found = 1'b1;
        free_slot  = NODE_W'(i);
      end
    end
  end

  assign ins_slot  = hit ? hit_slot : free_slot;
  assign ins_write = ins_valid_i & (hit ? (ins_f_i < ent_f_q[hit_slot]) : free_found);
  assign pop_xfer  = pop_valid_o & pop_ready_i;
  // strict compare keeps the lower slot on a tie
  assign scan_take = ent_valid_q[scan_idx_q] &&
                     (!best_found_q || ent_f_q[scan_idx_q] < best_f_q);

  always_ff @(posedge sync or posedge reset)
  begin
    if (reset)
    begin
      ent_valid_q  <= '0;
      scan_idx_q   <= '0;
      scan_done_q  <= 1'b0;
      best_found_q <= 1'b0;
      best_slot_q  <= '0;
      best_f_q     <= '0;
    end
    else if (clear_i || ins_valid_i || pop_xfer)
    begin
      scan_idx_q   <= '0;                    // contents changed, rescan
      scan_done_q  <= 1'b0;
      best_found_q <= 1'b0;
      if (clear_i)
        ent_valid_q <= '0;
      else
      begin
        if (pop_xfer)
          ent_valid_q[best_slot_q] <= 1'b0;
        if (ins_write)
          ent_valid_q[ins_slot] <= 1'b1;
      end
    end
    else if (!scan_done_q)
    begin
      if (scan_take)
      begin
        best_found_q <= 1'b1;
        best_slot_q  <= scan_idx_q;
        best_f_q     <= ent_f_q[scan_idx_q];
      end
      scan_idx_q <= scan_idx_q + 1'b1;
      if (scan_idx_q == NODE_W'(NUM_NODES - 1))
        scan_done_q <= 1'b1;
    end
  end

  always_ff @(posedge sync)
  begin
    if (ins_write)
    begin
      ent_node_q[ins_slot] <= ins_node_i;
      ent_g_q[ins_slot]    <= ins_g_i;
      ent_f_q[ins_slot]    <= ins_f_i;
    end
  end

  assign pop_valid_o = scan_done_q & best_found_q;
  assign pop_node_o  = ent_node_q[best_slot_q];
  assign pop_g_o     = ent_g_q[best_slot_q];
  assign empty_o     = ~|ent_valid_q;

  a_no_overflow: assert property (
    @(posedge sync) disable iff (reset) ins_valid_i && !hit |-> free_found);

endmodule

/* verilog/search_ctrl.sv */
`timescale 1ns/1ns

module search_ctrl
  import astar_pkg::*;
(
  input  logic                 sync,
  input  logic                 reset,
  input  logic                 start_i,
  input  node_t                start_node_i,
  input  node_t                goal_node_i,
  input  logic [NUM_NODES-1:0] obstacle_map_i,
  input  logic                 pop_valid_i,
  output logic                 pop_ready_o,
  input  node_t                pop_node_i,
  input  logic [COST_W-1:0]    pop_g_i,
  input  logic                 empty_i,
  output logic                 ins_valid_o,
  output node_t                ins_node_o,
  output logic [COST_W-1:0]    ins_g_o,
  output logic [COST_W-1:0]    ins_f_o,
  output logic                 clear_o,
  output logic                 load_o,
  output node_t                load_node_o,
  input  logic                 cand_valid_i,
  output logic                 cand_ready_o,
  input  node_t                cand_node_i,
  input  logic                 cand_diag_i,
  input  logic                 cand_last_i,
  output logic                 busy_o,
  output logic                 done_o,
  output logic                 found_o,
  output logic [COST_W-1:0]    cost_o
);

  logic [ST_W-1:0]      state_q;
  logic                 found_q;
  logic [COST_W-1:0]    cost_q;
  node_t                cur_node_q;
  logic [COST_W-1:0]    cur_g_q;
  logic [COST_W-1:0]    g_mem_q [NUM_NODES];  // cost from start
  logic [NUM_NODES-1:0] closed_q;

  logic                 blocked;
  logic                 cur_closed;
  logic                 at_goal;
  logic [COST_W-1:0]    step_g;
  logic                 improve;

  // octile distance with 10 per straight step and 4 extra per diagonal
  function automatic logic [COST_W-1:0] octile(node_t a, node_t b);
    logic [COORD_W-1:0] dx;
    logic [COORD_W-1:0] dy;
    logic [COORD_W-1:0] hi;
    logic [COORD_W-1:0] lo;
    dx = (a.xy.x > b.xy.x) ? a.xy.x - b.xy.x : b.xy.x - a.xy.x;
    dy = (a.xy.y > b.xy.y) ? a.xy.y - b.xy.y : b.xy.y - a.xy.y;
    hi = (dx > dy) ? dx : dy;
    lo = (dx > dy) ? dy : dx;
    return COST_W'(STEP_STRAIGHT * hi + (STEP_DIAG - STEP_STRAIGHT) * lo);
  endfunction

  assign blocked    = obstacle_map_i[start_node_i.idx] | obstacle_map_i[goal_node_i.idx];
  assign cur_closed = closed_q[cur_node_q.idx];
  assign at_goal    = cur_node_q == goal_node_i;
  assign step_g     = cur_g_q + (cand_diag_i ? COST_W'(STEP_DIAG) : COST_W'(STEP_STRAIGHT));
  assign improve    = cand_valid_i && !obstacle_map_i[cand_node_i.idx] &&
                      !closed_q[cand_node_i.idx] && step_g < g_mem_q[cand_node_i.idx];

  assign busy_o       = state_q != ST_IDLE;
  assign clear_o      = state_q == ST_CHECK;
  assign pop_ready_o  = state_q == ST_POP;
  assign load_o       = state_q == ST_EVAL && !cur_closed && !at_goal;
  assign load_node_o  = cur_node_q;
  // hold the candidate for one extra cycle while g is written
  assign cand_ready_o = (state_q == ST_CAND && !improve) || state_q == ST_WRITE;

  assign ins_valid_o = state_q == ST_SEED || state_q == ST_WRITE;
  assign ins_node_o  = (state_q == ST_SEED) ? start_node_i : cand_node_i;
  assign ins_g_o     = (state_q == ST_SEED) ? '0 : step_g;
  assign ins_f_o     = ins_g_o + octile(ins_node_o, goal_node_i);

  assign found_o = found_q;
  assign cost_o  = cost_q;

  always_ff @(posedge sync or posedge reset)
  begin
    if (reset)
    begin
      state_q <= ST_IDLE;
      done_o  <= 1'b0;
      found_q <= 1'b0;
      cost_q  <= '0;
    end
    else
    begin
      done_o <= 1'b0;
      case (state_q)
        ST_IDLE:
          if (start_i)
          begin
            found_q <= 1'b0;
            cost_q  <= '0;
            state_q <= ST_CHECK;
          end
        ST_CHECK:
          if (blocked)
          begin
            done_o  <= 1'b1;                 // start or goal on an obstacle
            state_q <= ST_IDLE;
          end
          else
            state_q <= ST_SEED;
        ST_SEED:
          state_q <= ST_POP;
        ST_POP:
          if (pop_valid_i)
            state_q <= ST_EVAL;
          else if (empty_i)
          begin
            done_o  <= 1'b1;                 // nothing left to expand
            state_q <= ST_IDLE;
          end
        ST_EVAL:
          if (cur_closed)
            state_q <= ST_POP;
          else if (at_goal)
          begin
            done_o  <= 1'b1;
            found_q <= 1'b1;
            cost_q  <= cur_g_q;
            state_q <= ST_IDLE;
          end
          else
            state_q <= ST_CAND;
        ST_CAND:
          if (improve)
            state_q <= ST_WRITE;
          else if (cand_valid_i && cand_last_i)
            state_q <= ST_POP;
        ST_WRITE:
          state_q <= cand_last_i ? ST_POP : ST_CAND;
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge sync)
  begin
    if (state_q == ST_IDLE && start_i)
    begin
      closed_q <= '0;
      for (int i = 0; i < NUM_NODES; i++)
        g_mem_q[i] <= G_INF;
    end
    if (state_q == ST_SEED)
      g_mem_q[start_node_i.idx] <= '0;
    if (pop_ready_o && pop_valid_i)
    begin
      cur_node_q <= pop_node_i;
      cur_g_q    <= pop_g_i;
    end
    if (load_o)
      closed_q[cur_node_q.idx] <= 1'b1;  // expanded nodes are final
    if (state_q == ST_WRITE)
      g_mem_q[cand_node_i.idx] <= step_g;
  end

  a_done_pulse: assert property (
    @(posedge sync) disable iff (reset) done_o |=> !done_o);

endmodule
